/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vtb_dnn_status: dnn_status.f logic/*.sv tb/*.sv
	verilator --binary --timing -Wno-fatal -f dnn_status.f --top-module tb_dnn_status

run: obj_dir/Vtb_dnn_status
	./obj_dir/Vtb_dnn_status | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f dnn_status.f --top-module tb_dnn_status

clean:
	rm -rf obj_dir sim.log

/* dnn_status.f */
logic/dnn_status_pkg.sv
logic/hp_probe_if.sv
logic/axil_status_regs.sv
logic/event_counters.sv
logic/write_addr_log.sv
logic/dnn_status_top.sv
tb/status_checker.sv
tb/tb_dnn_status.sv

/* logic/axil_status_regs.sv */
module axil_status_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  dnn_status_pkg::axi_addr_t         awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  dnn_status_pkg::reg_word_t         wdata,
  input  logic [dnn_status_pkg::STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  dnn_status_pkg::axi_addr_t         araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output dnn_status_pkg::reg_word_t         rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  input  dnn_status_pkg::reg_word_t         status_regs [dnn_status_pkg::NUM_REGS],
  output logic                              start
);

  dnn_status_pkg::axil_fsm_t wr_state;
  dnn_status_pkg::reg_word_t ctrl_reg;
  logic                      ctrl_go_d;   // bit 0 one cycle late
  logic                      wr_accept;
  logic                      rd_accept;
  dnn_status_pkg::reg_idx_t  wr_idx;
  dnn_status_pkg::reg_idx_t  rd_idx;

  assign wr_idx = awaddr[dnn_status_pkg::ADDR_LSB +: dnn_status_pkg::IDX_W];
  assign rd_idx = araddr[dnn_status_pkg::ADDR_LSB +: dnn_status_pkg::IDX_W];

  assign wr_accept = awready && awvalid && wready && wvalid;
  assign rd_accept = arready && arvalid;

  // ====================
  // write channel
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= dnn_status_pkg::AXIL_IDLE;
      awready  <= 1'b0;
      wready   <= 1'b0;
    end else begin
      awready <= 1'b0;                    // ready is a single-cycle strobe
      wready  <= 1'b0;
      case (wr_state)
        dnn_status_pkg::AXIL_IDLE: begin
          if (wr_accept) begin
            wr_state <= dnn_status_pkg::AXIL_RESP;
          end else if (!awready && awvalid && wvalid) begin
            awready <= 1'b1;
            wready  <= 1'b1;
          end
        end
        dnn_status_pkg::AXIL_RESP: begin
          if (bready) begin
            wr_state <= dnn_status_pkg::AXIL_IDLE;
          end
        end
        default: wr_state <= dnn_status_pkg::AXIL_IDLE;
      endcase
    end
  end

  assign bvalid = (wr_state == dnn_status_pkg::AXIL_RESP);
  assign bresp  = dnn_status_pkg::RESP_OKAY;

  // control register, byte lanes per wstrb
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_reg <= dnn_status_pkg::CTRL_RESET;
    end else if (wr_accept && wr_idx == dnn_status_pkg::REG_CTRL) begin
      for (int b = 0; b < dnn_status_pkg::STRB_W; b++) begin
        if (wstrb[b]) begin
          ctrl_reg[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_go_d <= 1'b0;
    end else begin
      ctrl_go_d <= ctrl_reg[0];
    end
  end

  // any toggle of bit 0 kicks off a run
  assign start = ctrl_reg[0] ^ ctrl_go_d;

  // ====================
  // read channel
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= !arready && arvalid && !rvalid;
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata <= status_regs[rd_idx];       // held while master stalls
    end
  end

  assign rresp = dnn_status_pkg::RESP_OKAY;

endmodule

/* logic/dnn_status_pkg.sv */
package dnn_status_pkg;

  // ====================
  // widths
  // ====================
  localparam int REG_W    = 32;
  localparam int ADDR_W   = 32;
  localparam int STRB_W   = REG_W / 8;
  localparam int NUM_PU   = 2;
  localparam int NUM_REGS = 16;
  localparam int IDX_W    = $clog2(NUM_REGS);
  localparam int ADDR_LSB = 2;              // byte address to word index

  typedef logic [REG_W-1:0]  reg_word_t;
  typedef logic [ADDR_W-1:0] axi_addr_t;
  typedef logic [IDX_W-1:0]  reg_idx_t;
  typedef logic [2:0]        pu_state_t;    // pu controller state code
  typedef logic [1:0]        vecgen_state_t;
  typedef logic [NUM_PU-1:0] pu_mask_t;

  typedef enum logic {
    AXIL_IDLE,
    AXIL_RESP
  } axil_fsm_t;

  // reset values and responses
  localparam reg_word_t  CTRL_RESET     = '0;
  localparam axi_addr_t  ADDR_LOG_RESET = 32'hdeadbeef;
  localparam logic [1:0] RESP_OKAY      = 2'b00;

  // ====================
  // register map
  // ====================
  localparam reg_idx_t REG_CTRL           = 4'd0;  // write side of slot 0
  localparam reg_idx_t REG_START_COUNT    = 4'd0;
  localparam reg_idx_t REG_DONE_COUNT     = 4'd1;
  localparam reg_idx_t REG_PU_STATE       = 4'd2;
  localparam reg_idx_t REG_WR_ADDR_SECOND = 4'd3;
  localparam reg_idx_t REG_WR_ADDR_THIRD  = 4'd4;
  localparam reg_idx_t REG_WR_ADDR_LATEST = 4'd5;
  localparam reg_idx_t REG_READ_BEATS     = 4'd6;
  localparam reg_idx_t REG_WRITE_BEATS    = 4'd7;
  localparam reg_idx_t REG_PUSH_COUNT0    = 4'd8;
  localparam reg_idx_t REG_PUSH_COUNT1    = 4'd9;
  localparam reg_idx_t REG_VECGEN_STATE   = 4'd10;

endpackage

/* logic/dnn_status_top.sv */
module dnn_status_top (
  input  logic                              clk,
  input  logic                              reset,
  input  dnn_status_pkg::axi_addr_t         awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  dnn_status_pkg::reg_word_t         wdata,
  input  logic [dnn_status_pkg::STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  dnn_status_pkg::axi_addr_t         araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output dnn_status_pkg::reg_word_t         rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  output logic                              start,
  input  logic                              done,
  input  dnn_status_pkg::pu_mask_t          outbuf_push,
  input  dnn_status_pkg::pu_state_t         pu_state,
  input  dnn_status_pkg::vecgen_state_t     vecgen_state,
  input  logic                              hp_awvalid,
  input  logic                              hp_awready,
  input  dnn_status_pkg::axi_addr_t         hp_awaddr,
  input  logic                              hp_wvalid,
  input  logic                              hp_wready,
  input  logic                              hp_rvalid,
  input  logic                              hp_rready
);

  dnn_status_pkg::reg_word_t start_count;
  dnn_status_pkg::reg_word_t done_count;
  dnn_status_pkg::reg_word_t read_beats;
  dnn_status_pkg::reg_word_t write_beats;
  dnn_status_pkg::reg_word_t push_count [dnn_status_pkg::NUM_PU];
  dnn_status_pkg::axi_addr_t second_addr;
  dnn_status_pkg::axi_addr_t third_addr;
  dnn_status_pkg::axi_addr_t latest_addr;
  dnn_status_pkg::reg_word_t status_regs [dnn_status_pkg::NUM_REGS];

  hp_probe_if probe ();

  assign probe.awvalid = hp_awvalid;
  assign probe.awready = hp_awready;
  assign probe.awaddr  = hp_awaddr;
  assign probe.wvalid  = hp_wvalid;
  assign probe.wready  = hp_wready;
  assign probe.rvalid  = hp_rvalid;
  assign probe.rready  = hp_rready;

  // ====================
  // register map
  // ====================
  always_comb begin
    status_regs = '{default: '0};         // 11 to 15 read as zero
    status_regs[dnn_status_pkg::REG_START_COUNT]    = start_count;
    status_regs[dnn_status_pkg::REG_DONE_COUNT]     = done_count;
    status_regs[dnn_status_pkg::REG_PU_STATE]       = dnn_status_pkg::reg_word_t'(pu_state);
    status_regs[dnn_status_pkg::REG_WR_ADDR_SECOND] = second_addr;
    status_regs[dnn_status_pkg::REG_WR_ADDR_THIRD]  = third_addr;
    status_regs[dnn_status_pkg::REG_WR_ADDR_LATEST] = latest_addr;
    status_regs[dnn_status_pkg::REG_READ_BEATS]     = read_beats;
    status_regs[dnn_status_pkg::REG_WRITE_BEATS]    = write_beats;
    status_regs[dnn_status_pkg::REG_PUSH_COUNT0]    = push_count[0];
    status_regs[dnn_status_pkg::REG_PUSH_COUNT1]    = push_count[1];
    status_regs[dnn_status_pkg::REG_VECGEN_STATE]   =
      dnn_status_pkg::reg_word_t'(vecgen_state);
  end

  axil_status_regs regs_i (
    .clk         (clk),
    .reset       (reset),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .status_regs (status_regs),
    .start       (start)
  );

  event_counters counters_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .done        (done),
    .outbuf_push (outbuf_push),
    .probe       (probe),
    .start_count (start_count),
    .done_count  (done_count),
    .read_beats  (read_beats),
    .write_beats (write_beats),
    .push_count  (push_count)
  );

  write_addr_log addr_log_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .probe       (probe),
    .second_addr (second_addr),
    .third_addr  (third_addr),
    .latest_addr (latest_addr)
  );

endmodule

/* logic/event_counters.sv */
module event_counters (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      done,
  input  dnn_status_pkg::pu_mask_t  outbuf_push,
  hp_probe_if.observer              probe,
  output dnn_status_pkg::reg_word_t start_count,
  output dnn_status_pkg::reg_word_t done_count,
  output dnn_status_pkg::reg_word_t read_beats,
  output dnn_status_pkg::reg_word_t write_beats,
  output dnn_status_pkg::reg_word_t push_count [dnn_status_pkg::NUM_PU]
);

  logic read_beat;
  logic write_beat;

  assign read_beat  = probe.rvalid && probe.rready;
  assign write_beat = probe.wvalid && probe.wready;

  // ====================
  // run counters
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      start_count <= '0;
      done_count  <= '0;
    end else begin
      if (start) begin
        start_count <= start_count + 1'b1;
      end
      if (done) begin
        done_count <= done_count + 1'b1;
      end
    end
  end

  // memory port beats
  always_ff @(posedge clk) begin
    if (reset) begin
      read_beats  <= '0;
      write_beats <= '0;
    end else begin
      if (read_beat) begin
        read_beats <= read_beats + 1'b1;
      end
      if (write_beat) begin
        write_beats <= write_beats + 1'b1;
      end
    end
  end

  // one push counter per unit
  for (genvar i = 0; i < dnn_status_pkg::NUM_PU; i++) begin : g_push
    always_ff @(posedge clk) begin
      if (reset) begin
        push_count[i] <= '0;
      end else if (outbuf_push[i]) begin
        push_count[i] <= push_count[i] + 1'b1;
      end
    end
  end

endmodule

/* logic/hp_probe_if.sv */
interface hp_probe_if;

  logic                      awvalid;
  logic                      awready;
  dnn_status_pkg::axi_addr_t awaddr;
  logic                      wvalid;
  logic                      wready;
  logic                      rvalid;
  logic                      rready;

  modport source (
    output awvalid,
    output awready,
    output awaddr,
    output wvalid,
    output wready,
    output rvalid,
    output rready
  );

  modport observer (
    input awvalid,
    input awready,
    input awaddr,
    input wvalid,
    input wready,
    input rvalid,
    input rready
  );

endinterface

/* logic/write_addr_log.sv */
module write_addr_log (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  hp_probe_if.observer              probe,
  output dnn_status_pkg::axi_addr_t second_addr,
  output dnn_status_pkg::axi_addr_t third_addr,
  output dnn_status_pkg::axi_addr_t latest_addr
);

  logic       aw_hs;
  logic       log_hs;
  logic [2:0] seen;                       // first, second, third handshake done

  assign aw_hs  = probe.awvalid && probe.awready;
  assign log_hs = aw_hs && !start;        // start cycle only updates latest

  // ====================
  // valid chain
  // ====================
  always_ff @(posedge clk) begin
    if (reset || start) begin
      seen <= '0;
    end else if (aw_hs) begin
      seen <= {seen[1:0], 1'b1};
    end
  end

  // a slot follows every handshake until its own flag is set
  always_ff @(posedge clk) begin
    if (reset) begin
      second_addr <= dnn_status_pkg::ADDR_LOG_RESET;
      third_addr  <= dnn_status_pkg::ADDR_LOG_RESET;
      latest_addr <= dnn_status_pkg::ADDR_LOG_RESET;
    end else begin
      if (aw_hs) begin
        latest_addr <= probe.awaddr;
      end
      if (log_hs && !seen[1]) begin
        second_addr <= probe.awaddr;
      end
      if (log_hs && !seen[2]) begin
        third_addr <= probe.awaddr;
      end
    end
  end

endmodule

/* tb/status_checker.sv */
module status_checker (
  input  logic                              clk,
  input  logic                              reset,
  input  dnn_status_pkg::axi_addr_t         awaddr,
  input  logic                              awvalid,
  input  logic                              awready,
  input  dnn_status_pkg::reg_word_t         wdata,
  input  logic [dnn_status_pkg::STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  input  logic                              wready,
  input  logic [1:0]                        bresp,
  input  logic                              bvalid,
  input  dnn_status_pkg::axi_addr_t         araddr,
  input  logic                              arvalid,
  input  logic                              arready,
  input  dnn_status_pkg::reg_word_t         rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rvalid,
  input  logic                              rready,
  input  logic                              start,
  input  logic                              done,
  input  dnn_status_pkg::pu_mask_t          outbuf_push,
  input  dnn_status_pkg::pu_state_t         pu_state,
  input  dnn_status_pkg::vecgen_state_t     vecgen_state,
  input  logic                              hp_awvalid,
  input  logic                              hp_awready,
  input  dnn_status_pkg::axi_addr_t         hp_awaddr,
  input  logic                              hp_wvalid,
  input  logic                              hp_wready,
  input  logic                              hp_rvalid,
  input  logic                              hp_rready
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] EXP_OKAY = 2'b00;  // axi okay response

  int    error_count = 0;
  int    read_count = 0;
  string test_name = "startup";

  logic                      ctrl_bit;
  logic                      exp_start;     // start expected in this cycle
  dnn_status_pkg::reg_word_t start_cnt;
  dnn_status_pkg::reg_word_t done_cnt;
  dnn_status_pkg::reg_word_t rd_beats;
  dnn_status_pkg::reg_word_t wr_beats;
  dnn_status_pkg::reg_word_t push_cnt [dnn_status_pkg::NUM_PU];
  int                        log_depth;     // handshakes since start, up to 3
  dnn_status_pkg::axi_addr_t log_second;
  dnn_status_pkg::axi_addr_t log_third;
  dnn_status_pkg::axi_addr_t log_latest;
  dnn_status_pkg::reg_word_t exp_q [$];
  dnn_status_pkg::reg_idx_t  idx_q [$];

  task automatic begin_test(input string name);
    test_name = name;
  endtask

  // ====================
  // reference model
  // ====================
  function automatic dnn_status_pkg::reg_word_t expected_reg(
    input dnn_status_pkg::reg_idx_t idx
  );
    dnn_status_pkg::reg_word_t value;
    case (idx)
      dnn_status_pkg::REG_START_COUNT:    value = start_cnt;
      dnn_status_pkg::REG_DONE_COUNT:     value = done_cnt;
      dnn_status_pkg::REG_PU_STATE:       value = dnn_status_pkg::reg_word_t'(pu_state);
      dnn_status_pkg::REG_WR_ADDR_SECOND: value = log_second;
      dnn_status_pkg::REG_WR_ADDR_THIRD:  value = log_third;
      dnn_status_pkg::REG_WR_ADDR_LATEST: value = log_latest;
      dnn_status_pkg::REG_READ_BEATS:     value = rd_beats;
      dnn_status_pkg::REG_WRITE_BEATS:    value = wr_beats;
      dnn_status_pkg::REG_PUSH_COUNT0:    value = push_cnt[0];
      dnn_status_pkg::REG_PUSH_COUNT1:    value = push_cnt[1];
      dnn_status_pkg::REG_VECGEN_STATE:   value = dnn_status_pkg::reg_word_t'(vecgen_state);
      default:                            value = '0;
    endcase
    return value;
  endfunction

  task automatic reset_model();
    ctrl_bit   = 1'b0;
    exp_start  = 1'b0;
    start_cnt  = '0;
    done_cnt   = '0;
    rd_beats   = '0;
    wr_beats   = '0;
    push_cnt   = '{default: '0};
    log_depth  = 0;
    log_second = dnn_status_pkg::ADDR_LOG_RESET;
    log_third  = dnn_status_pkg::ADDR_LOG_RESET;
    log_latest = dnn_status_pkg::ADDR_LOG_RESET;
    exp_q.delete();
    idx_q.delete();
  endtask

  task automatic check_start();
    if (start !== exp_start) begin
      error_count++;
      if (exp_start) begin
        $display("%s: start pulse missing at %0t", test_name, $time);
      end else begin
        $display("%s: unexpected start pulse at %0t", test_name, $time);
      end
    end
  endtask

  task automatic check_bresp();
    if (bvalid && bresp !== EXP_OKAY) begin
      error_count++;
      $display("Fail %s: bresp expected %b actual %b", test_name, EXP_OKAY, bresp);
    end
  endtask

  task automatic track_reads();
    dnn_status_pkg::reg_word_t exp_val;
    dnn_status_pkg::reg_idx_t  idx;
    if (arvalid && arready) begin
      idx = dnn_status_pkg::reg_idx_t'(araddr >> dnn_status_pkg::ADDR_LSB);
      idx_q.push_back(idx);
      exp_q.push_back(expected_reg(idx));   // value at the accepting edge
    end
    if (rvalid && rready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("%s: read data returned without a request at %0t", test_name, $time);
      end else begin
        exp_val = exp_q.pop_front();
        idx     = idx_q.pop_front();
        read_count++;
        if (rdata !== exp_val) begin
          error_count++;
          $display("Fail %s: reg %0d expected %h actual %h", test_name, idx, exp_val, rdata);
        end
        if (rresp !== EXP_OKAY) begin
          error_count++;
          $display("Fail %s: rresp expected %b actual %b", test_name, EXP_OKAY, rresp);
        end
      end
    end
  endtask

  task automatic count_events();
    if (exp_start) start_cnt = start_cnt + 1;
    if (done) done_cnt = done_cnt + 1;
    if (hp_rvalid && hp_rready) rd_beats = rd_beats + 1;
    if (hp_wvalid && hp_wready) wr_beats = wr_beats + 1;
    for (int i = 0; i < dnn_status_pkg::NUM_PU; i++) begin
      if (outbuf_push[i]) push_cnt[i] = push_cnt[i] + 1;
    end
  endtask

  task automatic track_log();
    if (exp_start) begin
      log_depth = 0;
    end
    if (hp_awvalid && hp_awready) begin
      log_latest = hp_awaddr;
      if (!exp_start) begin
        if (log_depth < 2) log_second = hp_awaddr;
        if (log_depth < 3) begin
          log_third = hp_awaddr;
          log_depth++;
        end
      end
    end
  endtask

  // start follows the cycle after a write that flips bit 0
  task automatic track_ctrl();
    logic accept;
    accept    = awvalid && awready && wvalid && wready;
    exp_start = 1'b0;
    if (accept && (awaddr >> dnn_status_pkg::ADDR_LSB) == 0 && wstrb[0]
        && wdata[0] != ctrl_bit) begin
      ctrl_bit  = wdata[0];
      exp_start = 1'b1;
    end
  endtask

  // ====================
  // per-cycle compare
  // ====================
  always @(negedge clk) begin
    if (reset) begin
      reset_model();
      if (awready || wready || bvalid || arready || rvalid || start) begin
        error_count++;
        $display("reset: bus handshake outputs or start not low during reset at %0t", $time);
      end
    end else begin
      check_start();
      check_bresp();
      track_reads();
      count_events();
      track_log();
      track_ctrl();
    end
  end

  task automatic finish_checks();
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d register reads never returned data", exp_q.size());
    end
    if (read_count == 0) begin
      error_count++;
      $display("no register reads were compared");
    end
  endtask

endmodule

/* tb/tb_dnn_status.sv */
module tb_dnn_status;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 40;
  localparam int BUS_CYCLES   = 8;           // worst case for one bus access
  localparam int RAND_CYCLES  = 300;
  localparam int LOG_ROUNDS   = 12;
  localparam int STATE_ROUNDS = 8;
  localparam int STALL_CYCLES = 5;
  localparam int TEST_CYCLES  =
    16 * BUS_CYCLES +
    16 * 2 * BUS_CYCLES +
    2 * (RAND_CYCLES + 3 * BUS_CYCLES) +
    LOG_ROUNDS * (5 * BUS_CYCLES + 20) +
    STATE_ROUNDS * 2 * (BUS_CYCLES + STALL_CYCLES);
  localparam int WATCHDOG_NS  = 4 * TEST_CYCLES * CLK_PERIOD;
  localparam logic [11:0] CTRL_SEQ = 12'b0110_0101_1100;

  logic                                clk;
  logic                                reset;
  dnn_status_pkg::axi_addr_t           awaddr;
  logic                                awvalid;
  logic                                awready;
  dnn_status_pkg::reg_word_t           wdata;
  logic [dnn_status_pkg::STRB_W-1:0]   wstrb;
  logic                                wvalid;
  logic                                wready;
  logic [1:0]                          bresp;
  logic                                bvalid;
  logic                                bready;
  dnn_status_pkg::axi_addr_t           araddr;
  logic                                arvalid;
  logic                                arready;
  dnn_status_pkg::reg_word_t           rdata;
  logic [1:0]                          rresp;
  logic                                rvalid;
  logic                                rready;
  logic                                start;
  logic                                done;
  dnn_status_pkg::pu_mask_t            outbuf_push;
  dnn_status_pkg::pu_state_t           pu_state;
  dnn_status_pkg::vecgen_state_t       vecgen_state;
  logic                                hp_awvalid;
  logic                                hp_awready;
  dnn_status_pkg::axi_addr_t           hp_awaddr;
  logic                                hp_wvalid;
  logic                                hp_wready;
  logic                                hp_rvalid;
  logic                                hp_rready;

  integer seed = 32'h621ec1bc;
  logic   ctrl_now;                          // last bit 0 written to reg 0

  dnn_status_top dut_i (.*);

  status_checker check_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // ====================
  // bus tasks
  // ====================
  task automatic write_reg(input dnn_status_pkg::reg_idx_t idx,
                           input dnn_status_pkg::reg_word_t data,
                           input logic [dnn_status_pkg::STRB_W-1:0] strb);
    logic hs;
    awaddr  = dnn_status_pkg::axi_addr_t'(idx) << dnn_status_pkg::ADDR_LSB;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    do begin
      @(negedge clk);
      hs = awready && wready;
      next_cycle();
    end while (!hs);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do begin
      @(negedge clk);
      hs = bvalid;
      next_cycle();
    end while (!hs);
    bready = 1'b0;
    if (idx == dnn_status_pkg::REG_CTRL && strb[0]) ctrl_now = data[0];
  endtask

  task automatic read_reg(input dnn_status_pkg::reg_idx_t idx, input int stall);
    logic hs;
    araddr  = dnn_status_pkg::axi_addr_t'(idx) << dnn_status_pkg::ADDR_LSB;
    arvalid = 1'b1;
    rready  = (stall == 0);
    do begin
      @(negedge clk);
      hs = arready;
      next_cycle();
    end while (!hs);
    arvalid = 1'b0;
    repeat (stall) next_cycle();             // master holds off
    rready = 1'b1;
    do begin
      @(negedge clk);
      hs = rvalid;
      next_cycle();
    end while (!hs);
    rready = 1'b0;
  endtask

  // ====================
  // tests
  // ====================
  task automatic reset_values();
    check_i.begin_test("reset values");
    for (int i = 0; i < dnn_status_pkg::NUM_REGS; i++) begin
      read_reg(dnn_status_pkg::reg_idx_t'(i), 0);
    end
  endtask

  task automatic ctrl_writes();
    dnn_status_pkg::reg_word_t data;
    check_i.begin_test("control writes");
    for (int i = 0; i < 12; i++) begin
      data    = $random(seed);
      data[0] = CTRL_SEQ[i];
      write_reg(dnn_status_pkg::REG_CTRL, data, 4'hf);
      read_reg(dnn_status_pkg::REG_START_COUNT, 0);
    end
    write_reg(4'd3, 32'hffff_ffff, 4'hf);    // other slots are ignored
    write_reg(4'd7, 32'h5a5a_a5a5, 4'hf);
    write_reg(dnn_status_pkg::REG_CTRL, {31'd0, ~ctrl_now}, 4'he);
    read_reg(dnn_status_pkg::REG_START_COUNT, 0);
    read_reg(4'd3, 0);
    read_reg(4'd7, 0);
  endtask

  task automatic event_pulses();
    dnn_status_pkg::reg_word_t rnd;
    check_i.begin_test("done and push");
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd         = $random(seed);
      done        = rnd[0];
      outbuf_push = rnd[2:1];
      next_cycle();
    end
    done        = 1'b0;
    outbuf_push = '0;
    read_reg(dnn_status_pkg::REG_DONE_COUNT, 0);
    read_reg(dnn_status_pkg::REG_PUSH_COUNT0, 0);
    read_reg(dnn_status_pkg::REG_PUSH_COUNT1, 0);
  endtask

  task automatic beat_traffic();
    dnn_status_pkg::reg_word_t rnd;
    check_i.begin_test("memory beats");
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd       = $random(seed);
      hp_wvalid = rnd[0];
      hp_wready = rnd[1];
      hp_rvalid = rnd[2];
      hp_rready = rnd[3];
      next_cycle();
    end
    {hp_wvalid, hp_wready, hp_rvalid, hp_rready} = 4'b0000;
    read_reg(dnn_status_pkg::REG_READ_BEATS, 0);
    read_reg(dnn_status_pkg::REG_WRITE_BEATS, 0);
  endtask

  task automatic addr_log_rounds();
    dnn_status_pkg::reg_word_t rnd;
    int unsigned               k;
    int unsigned               seen;
    check_i.begin_test("address log");
    for (int r = 0; r < LOG_ROUNDS; r++) begin
      hp_awaddr  = $random(seed);
      hp_awvalid = (r % 3 == 1);             // busy port across the start cycle
      hp_awready = (r % 3 == 1);
      write_reg(dnn_status_pkg::REG_CTRL, {31'd0, ~ctrl_now}, 4'h1);
      hp_awvalid = 1'b0;
      hp_awready = 1'b0;
      k    = $unsigned($random(seed)) % 7;
      seen = 0;
      while (seen < k) begin
        rnd        = $random(seed);
        hp_awaddr  = $random(seed);
        hp_awvalid = rnd[0] | rnd[1];
        hp_awready = rnd[2] | rnd[3];
        if (hp_awvalid && hp_awready) seen++;
        next_cycle();
      end
      hp_awvalid = 1'b0;
      hp_awready = 1'b0;
      read_reg(dnn_status_pkg::REG_WR_ADDR_SECOND, 0);
      read_reg(dnn_status_pkg::REG_WR_ADDR_THIRD, 0);
      read_reg(dnn_status_pkg::REG_WR_ADDR_LATEST, 0);
      read_reg(dnn_status_pkg::REG_START_COUNT, 0);
    end
  endtask

  task automatic state_reads();
    dnn_status_pkg::reg_word_t rnd;
    int                        stall;
    check_i.begin_test("state pass-through");
    for (int r = 0; r < STATE_ROUNDS; r++) begin
      rnd          = $random(seed);
      pu_state     = rnd[2:0];
      vecgen_state = rnd[4:3];
      stall        = (r % 2 == 1) ? STALL_CYCLES : 0;
      read_reg(dnn_status_pkg::REG_PU_STATE, stall);
      read_reg(dnn_status_pkg::REG_VECGEN_STATE, stall);
    end
  endtask

  initial begin
    reset        = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    done         = 1'b0;
    outbuf_push  = '0;
    pu_state     = '0;
    vecgen_state = '0;
    hp_awvalid   = 1'b0;
    hp_awready   = 1'b0;
    hp_awaddr    = '0;
    hp_wvalid    = 1'b0;
    hp_wready    = 1'b0;
    hp_rvalid    = 1'b0;
    hp_rready    = 1'b0;
    ctrl_now     = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_values();
    ctrl_writes();
    event_pulses();
    beat_traffic();
    addr_log_rounds();
    state_reads();
    repeat (4) next_cycle();

    check_i.finish_checks();
    $display("done: %0d reads compared, %0d errors", check_i.read_count, check_i.error_count);
    if (check_i.error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
